/* verilog.f */
hdl/game_link_pkg.sv
hdl/uart_rx.sv
hdl/frame_parser_ctrl.sv
hdl/record_assembler.sv
hdl/link_monitor.sv
hdl/game_link_rx.sv
tb/tb_game_link_rx.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the game link receiver testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_game_link_rx

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_game_link_rx -f verilog.f -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$LOG"; then
    echo "Testbench reported failure, see $LOG"
    exit 1
fi

echo "Run finished, log in $LOG"
exit 0

/* tb/tb_game_link_rx.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_game_link_rx;

    localparam int CLKS_PER_BIT    = 8;
    localparam int BYTE_BITS       = 11; // start, 8 data, stop, idle gap
    localparam int FRAME_BYTES_MAX = 45;
    localparam int NUM_FRAMES      = 16;
    localparam int PUBLISH_WAIT    = 4 * CLKS_PER_BIT;
    localparam int TIMEOUT_CYCLES  =
        2 * NUM_FRAMES * FRAME_BYTES_MAX * BYTE_BITS * CLKS_PER_BIT + 2000;

    logic                       clk;
    logic                       rst;
    logic                       rx_serial;
    game_link_pkg::game_state_t game_state;
    logic                       data_valid;
    game_link_pkg::link_stats_t link_stats;

    int                         errors;
    int                         checks;
    int                         cycles;
    int                         pulse_count;
    int                         exp_bytes;
    int                         exp_frames;
    int                         exp_errors;
    logic [31:0]                lfsr;
    game_link_pkg::game_state_t published;   // game_state seen with data_valid
    game_link_pkg::game_state_t last_record;

    game_link_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_game_link_rx (
        .clk       (clk),
        .rst       (rst),
        .rx_serial (rx_serial),
        .game_state(game_state),
        .data_valid(data_valid),
        .link_stats(link_stats)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (data_valid) begin
            pulse_count = pulse_count + 1;
            published   = game_state;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("checks: %0d  errors: %0d", checks, errors + 1);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    function automatic logic [3:0] rand_digit();
        logic [3:0] d;
        d = 4'(rand_bits(4));
        return (d > 4'd9) ? d - 4'd10 : d;
    endfunction

    function automatic logic [11:0] rand_bcd3();
        return {rand_digit(), rand_digit(), rand_digit()};
    endfunction

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_bit(input logic b);
        rx_serial = b;
        repeat (CLKS_PER_BIT) @(posedge clk);
        #1;
    endtask

    // also keeps the expected link statistics
    task automatic send_byte(input logic [7:0] data, input logic bad_stop);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(data[i]);
        end
        drive_bit(!bad_stop);
        drive_bit(1'b1);
        if (bad_stop) begin
            exp_errors++;
        end else begin
            exp_bytes++;
            if (data == game_link_pkg::CHAR_LF) exp_frames++;
        end
    endtask

    task automatic send_text(input string s);
        for (int i = 0; i < s.len(); i++) begin
            send_byte(s[i], 1'b0);
        end
        send_byte(game_link_pkg::CHAR_CR, 1'b0);
        send_byte(game_link_pkg::CHAR_LF, 1'b0);
    endtask

    // boss hp tens is sent as a full digit
    task automatic send_frame(input game_link_pkg::game_state_t g, input logic [3:0] tens);
        string s;
        s = $sformatf("C%0d%0d%0d,%0d%0d%0d|%0d|%0d|%0d|%0d|B%0d%0d%0d,%0d%0d%0d|%0d%0d",
                      g.player.x[11:8], g.player.x[7:4], g.player.x[3:0],
                      g.player.y[11:8], g.player.y[7:4], g.player.y[3:0],
                      g.player.hp, g.player.aggro, g.player.flip_h, g.player.class_id,
                      g.boss.x[11:8], g.boss.x[7:4], g.boss.x[3:0],
                      g.boss.y[11:8], g.boss.y[7:4], g.boss.y[3:0],
                      tens, g.boss.hp[3:0]);
        send_text(s);
    endtask

    function automatic game_link_pkg::game_state_t expected_record(
        input game_link_pkg::game_state_t g,
        input logic [3:0]                 tens
    );
        game_link_pkg::game_state_t r;
        r = g;
        r.boss.hp[6:4] = tens[2:0];
        return r;
    endfunction

    task automatic check_stats(input string name);
        game_link_pkg::link_stats_t exp;
        exp.byte_count  = 16'(exp_bytes);
        exp.frame_count = 16'(exp_frames);
        exp.error_count = 8'(exp_errors);
        checks++;
        assert (link_stats == exp) else begin
            errors++;
            $display("Mismatch at %0t: %s link_stats %h, expected %h",
                     $time, name, link_stats, exp);
        end
    endtask

    task automatic check_publish(input game_link_pkg::game_state_t expected,
                                 input int n_before, input string name);
        int waited;
        waited = 0;
        while (pulse_count == n_before && waited < PUBLISH_WAIT) begin
            step_cycle();
            waited++;
        end
        repeat (4) step_cycle();
        checks++;
        assert (pulse_count == n_before + 1) else begin
            errors++;
            $display("%s: expected one data_valid pulse but saw %0d",
                     name, pulse_count - n_before);
        end
        checks++;
        assert (published == expected) else begin
            errors++;
            $display("Mismatch at %0t: %s game_state %h, expected %h",
                     $time, name, published, expected);
        end
        check_stats(name);
        last_record = expected;
    endtask

    function automatic game_link_pkg::game_state_t fixed_state();
        game_link_pkg::game_state_t g;
        g.player.x        = 12'h407;
        g.player.y        = 12'h089;
        g.player.hp       = 4'd7;
        g.player.aggro    = 4'd3;
        g.player.flip_h   = 1'b1;
        g.player.class_id = 2'd2;
        g.boss.x          = 12'h512;
        g.boss.y          = 12'h036;
        g.boss.hp         = {3'd0, 4'd4};
        return g;
    endfunction

    task automatic test_reset_values();
        checks++;
        assert (game_state == '0 && link_stats == '0 && data_valid == 1'b0) else begin
            errors++;
            $display("Mismatch at %0t: outputs not zero after reset", $time);
        end
    endtask

    task automatic test_fixed_frame();
        int n0;
        n0 = pulse_count;
        send_frame(fixed_state(), 4'd9); // tens 9 keeps only 3'd1
        check_publish(expected_record(fixed_state(), 4'd9), n0, "fixed frame");
    endtask

    task automatic test_random_frames();
        game_link_pkg::game_state_t g;
        logic [3:0]                 tens;
        int                         n0;
        for (int i = 0; i < 10; i++) begin
            g.player.x        = rand_bcd3();
            g.player.y        = rand_bcd3();
            g.player.hp       = rand_digit();
            g.player.aggro    = rand_digit();
            g.player.flip_h   = rand_bits(1) != 0;
            g.player.class_id = 2'(rand_bits(2));
            g.boss.x          = rand_bcd3();
            g.boss.y          = rand_bcd3();
            g.boss.hp         = {3'd0, rand_digit()};
            tens              = rand_digit();
            n0                = pulse_count;
            send_frame(g, tens);
            check_publish(expected_record(g, tens), n0, $sformatf("random frame %0d", i));
        end
    endtask

    task automatic test_tolerance();
        game_link_pkg::game_state_t exp;
        int                         n0;
        test_fixed_frame(); // leaves flip set in the staged record
        exp.player.x        = 12'h407;
        exp.player.y        = 12'h089;
        exp.player.hp       = 4'd5;
        exp.player.aggro    = 4'd2;
        exp.player.flip_h   = 1'b0;
        exp.player.class_id = 2'd1;
        exp.boss.x          = 12'h300;
        exp.boss.y          = 12'h120;
        exp.boss.hp         = {3'd5, 4'd6};
        n0 = pulse_count;
        send_text("C 4 0 7 3,0 8 9|1 5|2|x|1|B 3 0 0,1 2 0|5 6");
        check_publish(exp, n0, "tolerance frame");
    endtask

    task automatic test_stop_error();
        int n0;
        send_byte(8'hA5, 1'b1);
        repeat (4) step_cycle();
        check_stats("bad stop bit");
        n0 = pulse_count;
        send_frame(fixed_state(), 4'd3);
        check_publish(expected_record(fixed_state(), 4'd3), n0, "frame after error");
    endtask

    task automatic test_lone_lf();
        int n0;
        n0 = pulse_count;
        send_byte(game_link_pkg::CHAR_LF, 1'b0);
        check_publish(last_record, n0, "lone LF");
    endtask

    initial begin
        rst         = 1'b1;
        rx_serial   = 1'b1;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        pulse_count = 0;
        exp_bytes   = 0;
        exp_frames  = 0;
        exp_errors  = 0;
        lfsr        = 32'h11fa_79f7;
        published   = '0;
        last_record = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (2) step_cycle();

        test_reset_values();
        test_fixed_frame();
        test_random_frames();
        test_tolerance();
        test_stop_error();
        test_lone_lf();

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/game_link_rx.sv */
`timescale 1ns/100ps
`default_nettype none

module game_link_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rx_serial,
    output game_link_pkg::game_state_t game_state,
    output logic                       data_valid,
    output game_link_pkg::link_stats_t link_stats
);

    logic [7:0]                 rx_data;
    logic                       rx_valid;
    logic                       frame_error;
    game_link_pkg::digit_load_t digit_load;
    logic                       stage_clear;
    logic                       commit;

    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_uart_rx (
        .clk        (clk),
        .rst        (rst),
        .rx_serial  (rx_serial),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .frame_error(frame_error)
    );

    frame_parser_ctrl u_frame_parser_ctrl (
        .clk        (clk),
        .rst        (rst),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .digit_load (digit_load),
        .stage_clear(stage_clear),
        .commit     (commit)
    );

    record_assembler u_record_assembler (
        .clk        (clk),
        .rst        (rst),
        .digit_load (digit_load),
        .stage_clear(stage_clear),
        .commit     (commit),
        .game_state (game_state),
        .data_valid (data_valid)
    );

    link_monitor u_link_monitor (
        .clk        (clk),
        .rst        (rst),
        .rx_valid   (rx_valid),
        .frame_error(frame_error),
        .commit     (commit),
        .link_stats (link_stats)
    );

endmodule

`default_nettype wire

/* hdl/link_monitor.sv */
`timescale 1ns/100ps
`default_nettype none

module link_monitor (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       rx_valid,
    input  logic                       frame_error,
    input  logic                       commit,
    output game_link_pkg::link_stats_t link_stats
);

    // all counters wrap
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            link_stats <= '0;
        end else begin
            if (rx_valid) begin
                link_stats.byte_count <= link_stats.byte_count + 16'd1;
            end
            if (commit) begin
                link_stats.frame_count <= link_stats.frame_count + 16'd1;
            end
            if (frame_error) begin
                link_stats.error_count <= link_stats.error_count + 8'd1; // bad stop bit
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/record_assembler.sv */
`timescale 1ns/100ps
`default_nettype none

module record_assembler (
    input  logic                       clk,
    input  logic                       rst,
    input  game_link_pkg::digit_load_t digit_load,
    input  logic                       stage_clear,
    input  logic                       commit,
    output game_link_pkg::game_state_t game_state,
    output logic                       data_valid
);

    game_link_pkg::game_state_t staged;

    // writes one digit of a three-digit bcd value with the msd at index 0
    function automatic logic [11:0] put_bcd3(
        input logic [11:0] cur,
        input logic [1:0]  index,
        input logic [3:0]  nibble
    );
        logic [11:0] res;
        res = cur;
        case (index)
            2'd0:    res[11:8] = nibble;
            2'd1:    res[7:4]  = nibble;
            2'd2:    res[3:0]  = nibble;
            default: res       = cur;
        endcase
        return res;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            staged <= '0;
        end else if (stage_clear) begin
            staged <= '0;
        end else if (digit_load.load) begin
            case (digit_load.field)
                game_link_pkg::FIELD_P_X:
                    staged.player.x <= put_bcd3(staged.player.x, digit_load.index,
                                                digit_load.nibble);
                game_link_pkg::FIELD_P_Y:
                    staged.player.y <= put_bcd3(staged.player.y, digit_load.index,
                                                digit_load.nibble);
                game_link_pkg::FIELD_P_HP:    staged.player.hp       <= digit_load.nibble;
                game_link_pkg::FIELD_P_AGGRO: staged.player.aggro    <= digit_load.nibble;
                game_link_pkg::FIELD_P_FLIP:  staged.player.flip_h   <= digit_load.nibble[0];
                game_link_pkg::FIELD_P_CLASS: staged.player.class_id <= digit_load.nibble[1:0];
                game_link_pkg::FIELD_B_X:
                    staged.boss.x <= put_bcd3(staged.boss.x, digit_load.index,
                                              digit_load.nibble);
                game_link_pkg::FIELD_B_Y:
                    staged.boss.y <= put_bcd3(staged.boss.y, digit_load.index,
                                              digit_load.nibble);
                game_link_pkg::FIELD_B_HP: begin
                    if (digit_load.index == 2'd0) begin
                        staged.boss.hp[6:4] <= digit_load.nibble[2:0]; // tens truncated
                    end else begin
                        staged.boss.hp[3:0] <= digit_load.nibble;
                    end
                end
                default: staged <= staged;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            game_state <= '0;
            data_valid <= 1'b0;
        end else begin
            data_valid <= commit;
            if (commit) game_state <= staged;
        end
    end

endmodule

`default_nettype wire

/* hdl/frame_parser_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module frame_parser_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [7:0]                 rx_data,
    input  logic                       rx_valid,
    output game_link_pkg::digit_load_t digit_load,
    output logic                       stage_clear,
    output logic                       commit
);

    typedef enum logic [3:0] {
        IDLE,
        P_X,
        P_Y,
        P_HP,
        P_AGGRO,
        P_FLIP,
        P_CLASS,
        WAIT_BOSS,
        B_X,
        B_Y,
        B_HP,
        WAIT_LF
    } parse_state_e;

    parse_state_e              state;
    parse_state_e              sep_state;
    logic [7:0]                sep_char;
    logic [1:0]                idx;
    logic [1:0]                max_digits;
    logic                      multi_digit;
    game_link_pkg::field_sel_e cur_field;
    logic                      is_digit;
    logic                      bit_char;
    logic                      load_ok;

    assign is_digit = (rx_data >= game_link_pkg::CHAR_ZERO) &&
                      (rx_data <= game_link_pkg::CHAR_NINE);
    assign bit_char = (rx_data == game_link_pkg::CHAR_ZERO) ||
                      (rx_data == game_link_pkg::CHAR_ZERO + 8'd1);
    assign load_ok  = is_digit && (idx < max_digits) && (state != P_FLIP || bit_char);

    // each state has a single character that moves it on
    always_comb begin
        cur_field   = game_link_pkg::FIELD_NONE;
        max_digits  = 2'd0;
        multi_digit = 1'b0;
        sep_char    = game_link_pkg::CHAR_BAR;
        sep_state   = state;
        case (state)
            IDLE: begin
                sep_char  = game_link_pkg::CHAR_C;
                sep_state = P_X;
            end
            P_X: begin
                cur_field   = game_link_pkg::FIELD_P_X;
                max_digits  = 2'd3;
                multi_digit = 1'b1;
                sep_char    = game_link_pkg::CHAR_COMMA;
                sep_state   = P_Y;
            end
            P_Y: begin
                cur_field   = game_link_pkg::FIELD_P_Y;
                max_digits  = 2'd3;
                multi_digit = 1'b1;
                sep_state   = P_HP;
            end
            P_HP: begin
                cur_field  = game_link_pkg::FIELD_P_HP;
                max_digits = 2'd1; // last digit wins
                sep_state  = P_AGGRO;
            end
            P_AGGRO: begin
                cur_field  = game_link_pkg::FIELD_P_AGGRO;
                max_digits = 2'd1;
                sep_state  = P_FLIP;
            end
            P_FLIP: begin
                cur_field  = game_link_pkg::FIELD_P_FLIP;
                max_digits = 2'd1;
                sep_state  = P_CLASS;
            end
            P_CLASS: begin
                cur_field  = game_link_pkg::FIELD_P_CLASS;
                max_digits = 2'd1;
                sep_state  = WAIT_BOSS;
            end
            WAIT_BOSS: begin
                sep_char  = game_link_pkg::CHAR_B;
                sep_state = B_X;
            end
            B_X: begin
                cur_field   = game_link_pkg::FIELD_B_X;
                max_digits  = 2'd3;
                multi_digit = 1'b1;
                sep_char    = game_link_pkg::CHAR_COMMA;
                sep_state   = B_Y;
            end
            B_Y: begin
                cur_field   = game_link_pkg::FIELD_B_Y;
                max_digits  = 2'd3;
                multi_digit = 1'b1;
                sep_state   = B_HP;
            end
            B_HP: begin
                cur_field   = game_link_pkg::FIELD_B_HP;
                max_digits  = 2'd2;
                multi_digit = 1'b1;
                sep_char    = game_link_pkg::CHAR_CR;
                sep_state   = WAIT_LF;
            end
            default: begin
                sep_char  = game_link_pkg::CHAR_LF;
                sep_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            idx         <= '0;
            digit_load  <= '0;
            stage_clear <= 1'b0;
            commit      <= 1'b0;
        end else begin
            digit_load.load <= 1'b0;
            stage_clear     <= 1'b0;
            commit          <= 1'b0;
            if (rx_valid) begin
                if (rx_data == game_link_pkg::CHAR_LF) begin
                    state  <= IDLE; // publish from any state
                    idx    <= '0;
                    commit <= 1'b1;
                end else if (rx_data == sep_char) begin
                    state       <= sep_state;
                    idx         <= '0;
                    stage_clear <= (state == IDLE);
                end else if (load_ok) begin
                    digit_load <= '{field: cur_field, index: idx,
                                    nibble: rx_data[3:0], load: 1'b1};
                    if (multi_digit) idx <= idx + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/uart_rx.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx_serial,
    output logic [7:0] rx_data,
    output logic       rx_valid,
    output logic       frame_error
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_STOP,
        S_BREAK
    } rx_state_e;

    rx_state_e        state;
    logic             rx_meta;
    logic             rx_sync;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_cnt;
    logic             bit_tick;

    assign bit_tick = (clk_cnt == BIT_LAST);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_meta <= 1'b1; // line idles high
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_serial;
            rx_sync <= rx_meta;
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk) begin
        if (state == S_DATA && bit_tick) begin
            rx_data <= {rx_sync, rx_data[7:1]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= S_IDLE;
            clk_cnt     <= '0;
            bit_cnt     <= '0;
            rx_valid    <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            rx_valid    <= 1'b0;
            frame_error <= 1'b0;
            case (state)
                S_IDLE: begin
                    clk_cnt <= '0;
                    bit_cnt <= '0;
                    if (!rx_sync) state <= S_START;
                end
                S_START: begin
                    if (clk_cnt == HALF_LAST) begin
                        clk_cnt <= '0;
                        state   <= rx_sync ? S_IDLE : S_DATA; // high again = glitch
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                S_DATA: begin
                    if (bit_tick) begin
                        clk_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= S_STOP;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                S_STOP: begin
                    if (bit_tick) begin
                        clk_cnt <= '0;
                        if (rx_sync) begin
                            rx_valid <= 1'b1;
                            state    <= S_IDLE;
                        end else begin
                            frame_error <= 1'b1;
                            state       <= S_BREAK;
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                S_BREAK: begin
                    if (rx_sync) state <= S_IDLE; // wait out the low line
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/game_link_pkg.sv */
`default_nettype none

package game_link_pkg;

    localparam logic [7:0] CHAR_C     = 8'h43; // frame start
    localparam logic [7:0] CHAR_B     = 8'h42; // boss section
    localparam logic [7:0] CHAR_COMMA = 8'h2C;
    localparam logic [7:0] CHAR_BAR   = 8'h7C;
    localparam logic [7:0] CHAR_CR    = 8'h0D;
    localparam logic [7:0] CHAR_LF    = 8'h0A; // publishes staged record
    localparam logic [7:0] CHAR_ZERO  = 8'h30;
    localparam logic [7:0] CHAR_NINE  = 8'h39;

    typedef enum logic [3:0] {
        FIELD_NONE    = 4'd0,
        FIELD_P_X     = 4'd1,
        FIELD_P_Y     = 4'd2,
        FIELD_P_HP    = 4'd3,
        FIELD_P_AGGRO = 4'd4,
        FIELD_P_FLIP  = 4'd5,
        FIELD_P_CLASS = 4'd6,
        FIELD_B_X     = 4'd7,
        FIELD_B_Y     = 4'd8,
        FIELD_B_HP    = 4'd9
    } field_sel_e;

    typedef struct packed {
        field_sel_e field;
        logic [1:0] index;  // 0 = most significant digit
        logic [3:0] nibble;
        logic       load;
    } digit_load_t;

    typedef struct packed {
        logic [11:0] x;        // three bcd digits
        logic [11:0] y;
        logic [3:0]  hp;
        logic [3:0]  aggro;
        logic        flip_h;
        logic [1:0]  class_id;
    } player_state_t;

    typedef struct packed {
        logic [11:0] x;
        logic [11:0] y;
        logic [6:0]  hp;  // 3-bit tens, 4-bit units
    } boss_state_t;

    typedef struct packed {
        player_state_t player;
        boss_state_t   boss;
    } game_state_t;

    typedef struct packed {
        logic [15:0] byte_count;
        logic [15:0] frame_count;
        logic [7:0]  error_count;
    } link_stats_t;

endpackage

`default_nettype wire
